/* hw/mcu63701_pkg.sv */
// ####################
// Shared bus types, peripheral register map
// and reset values for the HD63701 mode 6 block
// ####################

package mcu63701_pkg;

  // Bus types
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  data_t;
  typedef logic [4:0]  port2_t;    // Port 2 has five pins

  // I/O port data registers
  localparam addr_t reg_p1_data = 16'h0002;
  localparam addr_t reg_p2_data = 16'h0003;
  localparam addr_t reg_p6_data = 16'h0017;

  // Timer block registers
  localparam addr_t reg_rg5     = 16'h0005;
  localparam addr_t reg_tcsr    = 16'h0008;  // Timer control/status
  localparam addr_t reg_frc_hi  = 16'h0009;
  localparam addr_t reg_frc_lo  = 16'h000A;
  localparam addr_t reg_ocr_hi  = 16'h000B;
  localparam addr_t reg_ocr_lo  = 16'h000C;
  localparam addr_t reg_icr_hi  = 16'h000D;
  localparam addr_t reg_icr_lo  = 16'h000E;
  localparam addr_t reg_rmcr    = 16'h0014;  // Rate and mode control

  // Reset values
  localparam data_t port_reset  = 8'hFF;    // All port pins high
  localparam addr_t ocr_reset   = 16'hFFFF; // Also used for icr
  localparam data_t rmcr_reset  = 8'h40;

  // Vector number reported with the timer interrupt
  localparam logic [3:0] irq2_vector = 4'd4;

endpackage

/* hw/mcu_onchip_mem.sv */
// ####################
// Synchronous byte memory, separate write
// and registered read ports
// ####################

`timescale 1ns/1ns

module mcu_onchip_mem #(
  parameter int aw = 8
) (
  input  logic                 mcu_clx2,
  input  logic [aw-1:0]        wr_addr,
  input  logic [aw-1:0]        rd_addr,
  input  logic                 we,
  input  mcu63701_pkg::data_t  wdata,
  output mcu63701_pkg::data_t  rdata
);

  import mcu63701_pkg::*;

  localparam int depth = 1 << aw;

  data_t mem [depth];

  // Write port
  always_ff @(posedge mcu_clx2) begin
    if (we) begin
      mem[wr_addr] <= wdata;
    end
  end

  // Read data lags the address by one clock
  always_ff @(posedge mcu_clx2) begin
    rdata <= mem[rd_addr];
  end

endmodule

/* hw/mcu_io_ports.sv */
// ####################
// Output latches for ports 1, 2 and 6
// with pin read-back
// ####################

`timescale 1ns/1ns

module mcu_io_ports (
  input  logic                  mcu_clx2,
  input  logic                  mcu_rst,
  input  mcu63701_pkg::addr_t   ad,
  input  logic                  wr,
  input  mcu63701_pkg::data_t   dout,
  input  mcu63701_pkg::data_t   pi1,
  input  mcu63701_pkg::port2_t  pi2,
  input  mcu63701_pkg::data_t   pi6,
  output mcu63701_pkg::data_t   po1,
  output mcu63701_pkg::port2_t  po2,
  output mcu63701_pkg::data_t   po6,
  output logic                  io_hit,
  output mcu63701_pkg::data_t   io_rdata
);

  import mcu63701_pkg::*;

  // Output latches
  always_ff @(posedge mcu_clx2 or posedge mcu_rst) begin
    if (mcu_rst) begin
      po1 <= port_reset;
      po2 <= port_reset[4:0];
      po6 <= port_reset;
    end else if (wr) begin
      case (ad)
        reg_p1_data: po1 <= dout;
        reg_p2_data: po2 <= dout[4:0];  // Upper three bits dropped
        reg_p6_data: po6 <= dout;
        default: ;
      endcase
    end
  end

  // Only the data registers belong to this block
  assign io_hit = (ad == reg_p1_data) || (ad == reg_p2_data) ||
                  (ad == reg_p6_data);

  // Reads see the pins, not the latches
  always_comb begin
    case (ad)
      reg_p1_data: io_rdata = pi1;
      reg_p2_data: io_rdata = {3'b111, pi2};
      reg_p6_data: io_rdata = pi6;
      default:     io_rdata = '0;
    endcase
  end

endmodule

/* hw/mcu_timer.sv */
// ####################
// Free-running timer with output compare,
// tcsr, rg5 and rmcr registers, irq2
// ####################

`timescale 1ns/1ns

module mcu_timer (
  input  logic                 mcu_clx2,
  input  logic                 mcu_rst,
  input  mcu63701_pkg::addr_t  ad,
  input  logic                 wr,
  input  mcu63701_pkg::data_t  dout,
  output logic                 irq2,
  output logic [3:0]           irq2_vec,
  output logic                 tim_hit,
  output mcu63701_pkg::data_t  tim_rdata
);

  import mcu63701_pkg::*;

  logic [16:0] frc;     // Bit 0 is a prescaler, count is 16:1
  data_t       frt;     // High byte held until the low byte write
  addr_t       ocr;
  addr_t       icr;
  data_t       rg5;
  data_t       rmcr;
  logic        oce;     // Compare interrupt enable
  logic        oci;     // Compare flag
  addr_t       count;

  assign count = frc[16:1];

  always_ff @(posedge mcu_clx2 or posedge mcu_rst) begin
    if (mcu_rst) begin
      frc  <= '0;
      frt  <= '0;
      ocr  <= ocr_reset;
      icr  <= ocr_reset;
      rg5  <= '0;
      rmcr <= rmcr_reset;
      oce  <= 1'b0;
    end else begin
      frc <= frc + 17'd1;
      if (wr) begin
        case (ad)
          reg_rg5:    rg5 <= dout;
          reg_tcsr:   oce <= dout[3];
          reg_frc_hi: frt <= dout;
          reg_frc_lo: frc <= {frt, dout, 1'b0};  // Overrides the increment
          reg_ocr_hi: ocr[15:8] <= dout;
          reg_ocr_lo: ocr[7:0]  <= dout;
          reg_icr_hi: icr[15:8] <= dout;
          reg_icr_lo: icr[7:0]  <= dout;
          reg_rmcr:   rmcr <= {dout[7:6], 6'b0};
          default: ;
        endcase
      end
    end
  end

  // Compare flag runs on the opposite edge
  always_ff @(negedge mcu_clx2 or posedge mcu_rst) begin
    if (mcu_rst) begin
      oci <= 1'b0;
    end else if ((ad == reg_ocr_hi) || (ad == reg_ocr_lo)) begin
      oci <= 1'b0;  // Any access to ocr clears it
    end else if (count == ocr) begin
      oci <= 1'b1;
    end
  end

  assign irq2     = oci & oce;
  assign irq2_vec = irq2_vector;

  assign tim_hit = (ad == reg_rg5) || (ad == reg_rmcr) ||
                   ((ad >= reg_tcsr) && (ad <= reg_icr_lo));

  always_comb begin
    case (ad)
      reg_rg5:    tim_rdata = rg5;
      reg_tcsr:   tim_rdata = {1'b0, oci, 2'b10, oce, 3'b000};
      reg_frc_hi: tim_rdata = count[15:8];
      reg_frc_lo: tim_rdata = count[7:0];
      reg_ocr_hi: tim_rdata = ocr[15:8];
      reg_ocr_lo: tim_rdata = ocr[7:0];
      reg_icr_hi: tim_rdata = icr[15:8];
      reg_icr_lo: tim_rdata = icr[7:0];
      reg_rmcr:   tim_rdata = rmcr;
      default:    tim_rdata = '0;
    endcase
  end

endmodule

/* hw/mcu_bus_decode.sv */
// ####################
// PROM and RAM decode, RAM write enable,
// read-data selection by priority
// ####################

`timescale 1ns/1ns

module mcu_bus_decode #(
  parameter mcu63701_pkg::addr_t biram_start = 16'h0040,
  parameter mcu63701_pkg::addr_t biram_end   = 16'h013F
) (
  input  mcu63701_pkg::addr_t  ad,
  input  logic                 wr,
  input  mcu63701_pkg::data_t  rom_rdata,
  input  mcu63701_pkg::data_t  ram_rdata,
  input  mcu63701_pkg::data_t  io_rdata,
  input  mcu63701_pkg::data_t  tim_rdata,
  input  logic                 io_hit,
  input  logic                 tim_hit,
  input  mcu63701_pkg::data_t  ext_di,
  output mcu63701_pkg::data_t  din,
  output logic                 ram_we,
  output logic                 ba
);

  logic rom_hit;
  logic ram_hit;

  assign rom_hit = (ad[15:14] == 2'b11);  // $C000-$FFFF
  assign ram_hit = (ad >= biram_start) && (ad <= biram_end);

  assign ram_we = ram_hit & wr;

  // Core may be stopped while it fetches from PROM
  assign ba = rom_hit;

  always_comb begin
    if (rom_hit) begin
      din = rom_rdata;
    end else if (ram_hit) begin
      din = ram_rdata;
    end else if (io_hit) begin
      din = io_rdata;
    end else if (tim_hit) begin
      din = tim_rdata;
    end else begin
      din = ext_di;  // Nothing internal answered
    end
  end

endmodule

/* hw/mcu63701_periph.sv */
// ####################
// On-chip peripherals of the HD63701 in
// mode 6: PROM, RAM, ports, timer, decode
// ####################

`timescale 1ns/1ns

module mcu63701_periph #(
  parameter mcu63701_pkg::addr_t biram_start = 16'h0040,
  parameter mcu63701_pkg::addr_t biram_end   = 16'h013F,
  parameter int                  rom_aw      = 14,
  parameter int                  ram_aw      = 8
) (
  input  logic                  mcu_clx2,
  input  logic                  mcu_rst,
  input  mcu63701_pkg::addr_t   ad,
  input  logic                  wr,
  input  mcu63701_pkg::data_t   dout,
  input  mcu63701_pkg::data_t   ext_di,
  input  mcu63701_pkg::data_t   pi1,
  input  mcu63701_pkg::port2_t  pi2,
  input  mcu63701_pkg::data_t   pi6,
  input  logic [rom_aw-1:0]     prog_addr,
  input  mcu63701_pkg::data_t   prom_din,
  input  logic                  prom_we,
  output mcu63701_pkg::data_t   din,
  output logic                  ba,
  output logic                  irq2,
  output logic [3:0]            irq2_vec,
  output mcu63701_pkg::data_t   po1,
  output mcu63701_pkg::port2_t  po2,
  output mcu63701_pkg::data_t   po6
);

  import mcu63701_pkg::*;

  data_t rom_rdata;
  data_t ram_rdata;
  data_t io_rdata;
  data_t tim_rdata;
  logic  io_hit;
  logic  tim_hit;
  logic  ram_we;

  // Instruction PROM, loaded only through the programming port
  mcu_onchip_mem #(.aw(rom_aw)) u_prom (
    .mcu_clx2 (mcu_clx2),
    .wr_addr  (prog_addr),
    .rd_addr  (ad[rom_aw-1:0]),
    .we       (prom_we),
    .wdata    (prom_din),
    .rdata    (rom_rdata)
  );

  // Work RAM
  mcu_onchip_mem #(.aw(ram_aw)) u_ram (
    .mcu_clx2 (mcu_clx2),
    .wr_addr  (ad[ram_aw-1:0]),
    .rd_addr  (ad[ram_aw-1:0]),
    .we       (ram_we),
    .wdata    (dout),
    .rdata    (ram_rdata)
  );

  mcu_io_ports u_io (
    .mcu_clx2 (mcu_clx2),
    .mcu_rst  (mcu_rst),
    .ad       (ad),
    .wr       (wr),
    .dout     (dout),
    .pi1      (pi1),
    .pi2      (pi2),
    .pi6      (pi6),
    .po1      (po1),
    .po2      (po2),
    .po6      (po6),
    .io_hit   (io_hit),
    .io_rdata (io_rdata)
  );

  mcu_timer u_timer (
    .mcu_clx2  (mcu_clx2),
    .mcu_rst   (mcu_rst),
    .ad        (ad),
    .wr        (wr),
    .dout      (dout),
    .irq2      (irq2),
    .irq2_vec  (irq2_vec),
    .tim_hit   (tim_hit),
    .tim_rdata (tim_rdata)
  );

  mcu_bus_decode #(
    .biram_start (biram_start),
    .biram_end   (biram_end)
  ) u_decode (
    .ad        (ad),
    .wr        (wr),
    .rom_rdata (rom_rdata),
    .ram_rdata (ram_rdata),
    .io_rdata  (io_rdata),
    .tim_rdata (tim_rdata),
    .io_hit    (io_hit),
    .tim_hit   (tim_hit),
    .ext_di    (ext_di),
    .din       (din),
    .ram_we    (ram_we),
    .ba        (ba)
  );

endmodule

/* dv/tb_mcu63701.sv */
// ####################
// Testbench for the HD63701 peripheral block:
// bus master, reference model, compare
// process, checks and watchdog
// ####################

`timescale 1ns/1ns

module tb_mcu63701;

  import mcu63701_pkg::*;

  localparam addr_t biram_start = 16'h0040;
  localparam addr_t biram_end   = 16'h013F;
  localparam int    rom_aw      = 14;
  localparam int    ram_aw      = 8;
  localparam int    ram_size    = biram_end - biram_start + 1;
  localparam int    clk_period  = 40;
  localparam int    ocr_gap     = 20;  // Compare point ahead of the loaded count
  localparam int    ram_writes  = 16;
  localparam int    prom_writes = 8;

  // Cycle budget per test
  localparam int len_reset = 24;
  localparam int len_ports = 4 * 14 + 8;
  localparam int len_ram   = ram_writes * 4 + 4 * 4 + 10;
  localparam int len_prom  = prom_writes * 3 + 10;
  localparam int len_timer = 30;
  localparam int len_irq   = 30 + 4 * ocr_gap + 20;
  localparam int watchdog_cycles = 3 + len_reset + len_ports + len_ram + len_prom +
                                   len_timer + len_irq + 200;

  logic        mcu_clx2;
  logic        mcu_rst;
  addr_t       ad;
  logic        wr;
  data_t       dout;
  data_t       ext_di;
  data_t       pi1;
  port2_t      pi2;
  data_t       pi6;
  logic [rom_aw-1:0] prog_addr;
  data_t       prom_din;
  logic        prom_we;
  data_t       din;
  logic        ba;
  logic        irq2;
  logic [3:0]  irq2_vec;
  data_t       po1;
  port2_t      po2;
  data_t       po6;

  // Reference model state
  data_t  ram_m [ram_size];
  data_t  prom_m [int];
  data_t  p1_m;
  port2_t p2_m;
  data_t  p6_m;
  data_t  rg5_m;
  data_t  rmcr_m;
  addr_t  ocr_m;
  addr_t  icr_m;
  logic   oce_m;
  logic   oci_m;

  // Reads waiting for the compare process
  data_t got_q [$];
  data_t exp_q [$];
  addr_t addr_q [$];

  integer seed;
  int     errors;
  int     test_errors;  // Error count when the current test began
  int     tests_run;
  int     tests_failed;
  logic   last_ba;

  mcu63701_periph #(
    .biram_start (biram_start),
    .biram_end   (biram_end),
    .rom_aw      (rom_aw),
    .ram_aw      (ram_aw)
  ) dut (
    .mcu_clx2  (mcu_clx2),
    .mcu_rst   (mcu_rst),
    .ad        (ad),
    .wr        (wr),
    .dout      (dout),
    .ext_di    (ext_di),
    .pi1       (pi1),
    .pi2       (pi2),
    .pi6       (pi6),
    .prog_addr (prog_addr),
    .prom_din  (prom_din),
    .prom_we   (prom_we),
    .din       (din),
    .ba        (ba),
    .irq2      (irq2),
    .irq2_vec  (irq2_vec),
    .po1       (po1),
    .po2       (po2),
    .po6       (po6)
  );

  always #(clk_period / 2) mcu_clx2 = ~mcu_clx2;

  // Expected din for any address
  function automatic data_t ref_read(input addr_t a);
    data_t r;
    int    off;
    off = int'(a[rom_aw-1:0]);
    if (a[15:14] == 2'b11) begin
      r = prom_m.exists(off) ? prom_m[off] : 8'hxx;
    end else if ((a >= biram_start) && (a <= biram_end)) begin
      r = ram_m[a - biram_start];
    end else begin
      case (a)
        reg_p1_data: r = pi1;
        reg_p2_data: r = {3'b111, pi2};
        reg_p6_data: r = pi6;
        reg_rg5:     r = rg5_m;
        reg_tcsr:    r = {1'b0, oci_m, 2'b10, oce_m, 3'b000};
        reg_frc_hi,
        reg_frc_lo:  r = 8'hxx;  // Count checked by range
        reg_ocr_hi:  r = ocr_m[15:8];
        reg_ocr_lo:  r = ocr_m[7:0];
        reg_icr_hi:  r = icr_m[15:8];
        reg_icr_lo:  r = icr_m[7:0];
        reg_rmcr:    r = rmcr_m;
        default:     r = ext_di;
      endcase
    end
    return r;
  endfunction

  task automatic model_write(input addr_t a, input data_t d);
    if ((a >= biram_start) && (a <= biram_end)) begin
      ram_m[a - biram_start] = d;
    end else begin
      case (a)
        reg_p1_data: p1_m = d;
        reg_p2_data: p2_m = d[4:0];
        reg_p6_data: p6_m = d;
        reg_rg5:     rg5_m = d;
        reg_tcsr:    oce_m = d[3];
        reg_ocr_hi: begin
          ocr_m[15:8] = d;
          oci_m = 1'b0;
        end
        reg_ocr_lo: begin
          ocr_m[7:0] = d;
          oci_m = 1'b0;
        end
        reg_icr_hi:  icr_m[15:8] = d;
        reg_icr_lo:  icr_m[7:0] = d;
        reg_rmcr:    rmcr_m = {d[7:6], 6'b0};
        default: ;
      endcase
    end
  endtask

  task automatic check_byte(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // Called on a rising edge, returns on a rising edge
  task automatic bus_write(input addr_t a, input data_t d);
    ad   <= a;
    dout <= d;
    wr   <= 1'b1;
    @(posedge mcu_clx2);
    wr <= 1'b0;
    @(posedge mcu_clx2);
    model_write(a, d);
  endtask

  task automatic bus_read(input addr_t a, output data_t d);
    ad <= a;
    wr <= 1'b0;
    @(posedge mcu_clx2);
    @(posedge mcu_clx2);
    d = din;        // Value settled before this edge
    last_ba = ba;
  endtask

  task automatic read_check(input addr_t a);
    data_t exp;
    data_t got;
    exp = ref_read(a);
    bus_read(a, got);
    got_q.push_back(got);
    exp_q.push_back(exp);
    addr_q.push_back(a);
    if ((a == reg_ocr_hi) || (a == reg_ocr_lo)) begin
      oci_m = 1'b0;
    end
  endtask

  task automatic end_test(input string name);
    @(negedge mcu_clx2);  // Compare process drains here
    @(posedge mcu_clx2);
    tests_run++;
    if (errors != test_errors) begin
      tests_failed++;
      $display("%s: fail, %0d errors", name, errors - test_errors);
    end else begin
      $display("%s: pass", name);
    end
    test_errors = errors;
  endtask

  // Compares queued reads away from the rising edge
  always @(negedge mcu_clx2) begin
    data_t g;
    data_t e;
    addr_t a;
    while (got_q.size() > 0) begin
      g = got_q.pop_front();
      e = exp_q.pop_front();
      a = addr_q.pop_front();
      check_byte(g, e, $sformatf("read at %h", a));
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    addr_t a;
    data_t d;
    data_t h;
    data_t l;
    data_t rh;
    data_t rl;
    int    i;
    int    n;
    int    off;
    int    diff;
    addr_t ram_addrs [$];
    int    prom_offs [$];

    seed = 93771;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    last_ba = 1'b0;
    mcu_clx2 = 1'b0;
    mcu_rst = 1'b1;
    ad = 16'h2000;
    wr = 1'b0;
    dout = '0;
    ext_di = '0;
    pi1 = '0;
    pi2 = '0;
    pi6 = '0;
    prog_addr = '0;
    prom_din = '0;
    prom_we = 1'b0;
    p1_m = 8'hFF;     // Port pins come out of reset high
    p2_m = 5'h1F;
    p6_m = 8'hFF;
    rg5_m = '0;
    rmcr_m = 8'h40;
    ocr_m = 16'hFFFF;
    icr_m = 16'hFFFF;
    oce_m = 1'b0;
    oci_m = 1'b0;

    repeat (3) @(posedge mcu_clx2);
    mcu_rst <= 1'b0;
    @(posedge mcu_clx2);

    check_byte(po1, p1_m, "po1 after reset");
    check_byte({3'b000, po2}, {3'b000, p2_m}, "po2 after reset");
    check_byte(po6, p6_m, "po6 after reset");
    check_bit(irq2, 1'b0, "irq2 after reset");
    read_check(reg_ocr_hi);
    read_check(reg_ocr_lo);
    read_check(reg_icr_hi);
    read_check(reg_icr_lo);
    read_check(reg_rmcr);
    read_check(reg_tcsr);
    end_test("reset state");

    repeat (4) begin
      bus_write(reg_p1_data, $random(seed));
      bus_write(reg_p2_data, $random(seed));
      bus_write(reg_p6_data, $random(seed));
      check_byte(po1, p1_m, "po1");
      check_byte({3'b000, po2}, {3'b000, p2_m}, "po2");
      check_byte(po6, p6_m, "po6");
      pi1 <= $random(seed);
      pi2 <= $random(seed);
      pi6 <= $random(seed);
      @(posedge mcu_clx2);
      read_check(reg_p1_data);
      read_check(reg_p2_data);
      read_check(reg_p6_data);
    end
    end_test("ports");

    for (i = 0; i < ram_writes; i++) begin
      a = biram_start + addr_t'($unsigned($random(seed)) % ram_size);
      bus_write(a, $random(seed));
      ram_addrs.push_back(a);
    end
    for (i = 0; i < ram_addrs.size(); i++) begin
      read_check(ram_addrs[i]);
    end
    for (i = 0; i < 4; i++) begin
      ext_di <= $random(seed);
      @(posedge mcu_clx2);
      a = (i == 0) ? 16'h2000 : 16'h0200 + ($random(seed) & 16'h7FFF);
      read_check(a);
      check_bit(last_ba, 1'b0, "ba outside PROM");
    end
    end_test("ram and external");

    for (i = 0; i < prom_writes; i++) begin
      off = $unsigned($random(seed)) % (1 << rom_aw);
      d = $random(seed);
      prog_addr <= off[rom_aw-1:0];
      prom_din  <= d;
      prom_we   <= 1'b1;
      @(posedge mcu_clx2);
      prom_m[off] = d;
      prom_offs.push_back(off);
    end
    prom_we <= 1'b0;
    @(posedge mcu_clx2);
    for (i = 0; i < prom_offs.size(); i++) begin
      read_check(16'hC000 | addr_t'(prom_offs[i]));
      check_bit(last_ba, 1'b1, "ba in PROM");
    end
    read_check(ram_addrs[0]);
    check_bit(last_ba, 1'b0, "ba in RAM");
    end_test("prom");

    bus_write(reg_rg5, $random(seed));
    read_check(reg_rg5);
    bus_write(reg_rmcr, $random(seed));
    read_check(reg_rmcr);
    bus_write(reg_tcsr, $random(seed));
    read_check(reg_tcsr);
    h = $random(seed) & 8'h7F;  // Keeps the count well below ocr
    l = $random(seed) & 8'h7F;  // No carry between the two reads
    bus_write(reg_frc_hi, h);
    bus_write(reg_frc_lo, l);
    bus_read(reg_frc_hi, rh);
    bus_read(reg_frc_lo, rl);
    diff = {rh, rl} - {h, l};
    if ((diff < 0) || (diff > 4)) begin
      $display("Count read back as %h after loading %h, outside the expected range",
               {rh, rl}, {h, l});
      errors++;
    end
    end_test("timer registers");

    bus_write(reg_tcsr, 8'h08);
    bus_write(reg_frc_hi, 8'h10);
    bus_write(reg_frc_lo, 8'h00);
    bus_write(reg_ocr_hi, 8'h10);
    bus_write(reg_ocr_lo, ocr_gap);
    ad <= 16'h2000;
    n = 0;
    // Five edges have passed since the count load
    while ((irq2 !== 1'b1) && (n < 4 * ocr_gap + 20)) begin
      @(posedge mcu_clx2);
      n++;
    end
    if (irq2 !== 1'b1) begin
      $display("irq2 never rose after ocr was set %0d counts ahead", ocr_gap);
      errors++;
    end else if ((5 + n < 2 * ocr_gap) || (5 + n > 2 * ocr_gap + 2)) begin
      $display("irq2 rose %0d cycles after the count load, expected about %0d",
               5 + n, 2 * ocr_gap + 1);
      errors++;
    end
    oci_m = 1'b1;  // Count has reached ocr
    read_check(reg_tcsr);
    check_byte({4'b0000, irq2_vec}, 8'h04, "irq2_vec");
    read_check(reg_ocr_lo);
    check_bit(irq2, 1'b0, "irq2 after ocr access");
    read_check(reg_tcsr);
    end_test("compare interrupt");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* mcu63701.f */
hw/mcu63701_pkg.sv
hw/mcu_onchip_mem.sv
hw/mcu_io_ports.sv
hw/mcu_timer.sv
hw/mcu_bus_decode.sv
hw/mcu63701_periph.sv
dv/tb_mcu63701.sv

/* Bender.yml */
package:
  name: mcu63701
  description: "On-chip peripheral block of an HD63701 in mode 6"

sources:
  # Package first, then leaf modules, then the top level
  - hw/mcu63701_pkg.sv
  - hw/mcu_onchip_mem.sv
  - hw/mcu_io_ports.sv
  - hw/mcu_timer.sv
  - hw/mcu_bus_decode.sv
  - hw/mcu63701_periph.sv

  - target: simulation
    files:
      - dv/tb_mcu63701.sv
